// File: logic/acc_pkg.sv
package acc_pkg;

	////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////
	typedef logic [7:0] word_t;      // One data byte
	typedef logic [7:0] addr_t;      // One memory address
	typedef logic [4:0] opcode_t;    // Instruction byte bits 7..3
	typedef logic [2:0] cond_t;      // Instruction byte bits 2..0

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////
	localparam opcode_t OP_NOP  = 5'b00000;
	localparam opcode_t OP_LDI  = 5'b00001;    // Acc = imm
	localparam opcode_t OP_ADDI = 5'b00010;    // Acc = acc + imm
	localparam opcode_t OP_SUBI = 5'b00011;    // Acc = acc - imm
	localparam opcode_t OP_ANDI = 5'b00100;    // Acc = acc & imm
	localparam opcode_t OP_XORI = 5'b00101;    // Acc = acc ^ imm
	localparam opcode_t OP_BRA  = 5'b00110;    // Conditional branch
	localparam opcode_t OP_JMP  = 5'b00111;
	localparam opcode_t OP_RTS  = 5'b01000;    // Return from subroutine
	localparam opcode_t OP_LDM  = 5'b01010;    // Acc = mem[imm]
	localparam opcode_t OP_STA  = 5'b01011;    // Mem[imm] = acc
	localparam opcode_t OP_OUT  = 5'b01100;    // Acc to output port
	localparam opcode_t OP_BSR  = 5'b10101;    // Subroutine call
	localparam opcode_t OP_HALT = 5'b11111;

	// Branch conditions, tested against the zero flag
	localparam cond_t COND_BEQ = 3'b000;
	localparam cond_t COND_BNE = 3'b001;
	localparam cond_t COND_ALW = 3'b010;

	////////////////////////////////////////////////////////////
	// Controller states
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		F_ADDR,
		F_INSTR,
		F_DECODE,
		F_OPERAND,
		F_WAIT_EXEC,
		F_BRANCH,
		F_CALL,
		F_RETURN,
		F_HALT
	} fetch_state_t;

	typedef enum logic [2:0] {
		E_IDLE,
		E_ALU,
		E_LOAD,
		E_STORE,
		E_OUT
	} exec_state_t;

	// True for opcodes followed by an operand byte
	function automatic logic needs_operand(opcode_t op);
		case (op)
			OP_LDI, OP_ADDI, OP_SUBI, OP_ANDI, OP_XORI: return 1'b1;
			OP_BRA, OP_JMP, OP_BSR, OP_LDM, OP_STA:     return 1'b1;
			default:                                    return 1'b0;
		endcase
	endfunction

endpackage

// File: logic/acc_mem.sv
`timescale 1ns/1ps

module acc_mem import acc_pkg::*; (
	input  logic  clk,
	// Program load, only used while reset is held
	input  logic  load_we,
	input  addr_t load_addr,
	input  word_t load_data,
	// Execute side
	input  logic  store_we,
	input  addr_t exec_addr,
	input  word_t store_data,
	// Fetch side
	input  addr_t fetch_addr,
	output word_t fetch_data,
	output word_t exec_data
);

	word_t mem [256];      // Unified program and data store

	addr_t wr_addr;        // Muxed write port
	word_t wr_data;
	logic  wr_en;

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////
	// Load port wins over a store
	assign wr_en   = load_we | store_we;
	assign wr_addr = load_we ? load_addr : exec_addr;
	assign wr_data = load_we ? load_data : store_data;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////
	// Two independent combinational reads, no arbitration needed
	assign fetch_data = mem[fetch_addr];    // Instruction and operand bytes
	assign exec_data  = mem[exec_addr];     // LDM data

endmodule

// File: logic/return_stack.sv
`timescale 1ns/1ps

module return_stack import acc_pkg::*; #(
	parameter int STACK_DEPTH = 4
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  push,
	input  logic  pop,
	input  addr_t push_addr,
	output addr_t top_addr
);

	localparam int PTR_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
	localparam int CNT_W = $clog2(STACK_DEPTH + 1);

	addr_t            entries [STACK_DEPTH];
	logic [PTR_W-1:0] ptr;         // Next free slot
	logic [PTR_W-1:0] ptr_next;    // Ptr + 1 with wrap
	logic [PTR_W-1:0] ptr_prev;    // Slot holding the top entry
	logic [CNT_W-1:0] count;       // Valid entries, saturates at depth

	assign ptr_next = (ptr == PTR_W'(STACK_DEPTH - 1)) ? '0 : ptr + 1'b1;
	assign ptr_prev = (ptr == '0) ? PTR_W'(STACK_DEPTH - 1) : ptr - 1'b1;

	// Empty stack reads as address 0
	assign top_addr = (count == '0) ? '0 : entries[ptr_prev];

	always_ff @(posedge clk) begin
		if (push) begin
			entries[ptr] <= push_addr;    // Full stack drops the oldest entry here
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr   <= '0;
			count <= '0;
		end else if (push) begin
			ptr <= ptr_next;
			if (count != CNT_W'(STACK_DEPTH))
				count <= count + 1'b1;
		end else if (pop && count != '0) begin
			ptr   <= ptr_prev;    // Pop on empty leaves pointer alone
			count <= count - 1'b1;
		end
	end

endmodule

// File: logic/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import acc_pkg::*; #(
	parameter addr_t RESET_PC = '0
) (
	input  logic    clk,
	input  logic    reset,
	// Instruction memory port
	output addr_t   fetch_addr,
	input  word_t   fetch_data,
	// Handoff to execute
	output logic    issue,
	output opcode_t issue_op,
	output word_t   issue_operand,
	input  logic    exec_idle,
	input  logic    zero_flag,
	// Return stack
	output logic    push,
	output logic    pop,
	output addr_t   push_addr,
	input  addr_t   top_addr,
	output logic    halted
);

	fetch_state_t state;
	addr_t        pc;
	word_t        instr_reg;      // Current instruction byte
	word_t        operand_reg;    // Its operand byte, when it has one
	opcode_t      op;
	cond_t        cond;
	logic         taken;          // Branch condition met
	logic         hold_op;        // Waits for execute but is not issued

	assign op      = instr_reg[7:3];
	assign cond    = instr_reg[2:0];
	assign hold_op = (op == OP_BRA) || (op == OP_HALT);

	// Zero flag only trusted while execute is idle
	assign taken = (cond == COND_ALW) ||
		(cond == COND_BEQ && zero_flag) ||
		(cond == COND_BNE && !zero_flag);

	////////////////////////////////////////////////////////////
	// Outputs decoded from state
	////////////////////////////////////////////////////////////
	assign fetch_addr    = pc;
	assign issue         = (state == F_WAIT_EXEC) && !hold_op;
	assign issue_op      = op;
	assign issue_operand = operand_reg;
	assign push          = (state == F_CALL);
	assign pop           = (state == F_RETURN);
	assign push_addr     = pc;                   // Already past the BSR operand
	assign halted        = (state == F_HALT);

	// Instruction and operand latches
	always_ff @(posedge clk) begin
		if (state == F_INSTR)
			instr_reg <= fetch_data;
		if (state == F_OPERAND)
			operand_reg <= fetch_data;
	end

	////////////////////////////////////////////////////////////
	// Fetch FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= F_ADDR;
			pc    <= RESET_PC;
		end else begin
			case (state)
				F_ADDR: state <= F_INSTR;              // Address settles
				F_INSTR: begin
					pc    <= pc + 8'd1;
					state <= F_DECODE;
				end
				F_DECODE: begin
					if (needs_operand(op))
						state <= F_OPERAND;
					else if (op == OP_RTS)
						state <= F_RETURN;
					else if (op == OP_OUT || op == OP_HALT)
						state <= F_WAIT_EXEC;
					else
						state <= F_ADDR;               // NOP and unlisted codes
				end
				F_OPERAND: begin
					pc <= pc + 8'd1;
					case (op)
						OP_JMP:  state <= F_BRANCH;
						OP_BSR:  state <= F_CALL;
						default: state <= F_WAIT_EXEC;  // Data ops and BRA
					endcase
				end
				F_WAIT_EXEC: begin
					// Transfer or resolve once execute is idle
					if (exec_idle) begin
						if (op == OP_HALT)
							state <= F_HALT;
						else if (op == OP_BRA && taken)
							state <= F_BRANCH;
						else
							state <= F_ADDR;
					end
				end
				F_BRANCH: begin
					pc    <= operand_reg;              // Jump target
					state <= F_ADDR;
				end
				F_CALL: state <= F_BRANCH;             // Push return address
				F_RETURN: begin
					pc    <= top_addr;
					state <= F_ADDR;
				end
				F_HALT: state <= F_HALT;               // Until next reset
				default: state <= F_ADDR;
			endcase
		end
	end

endmodule

// File: logic/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl import acc_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	// Handoff from fetch
	input  logic    issue,
	input  opcode_t issue_op,
	input  word_t   issue_operand,
	output logic    exec_idle,
	output logic    zero_flag,
	// Data memory port
	output addr_t   exec_addr,
	input  word_t   exec_data,
	output logic    store_we,
	output word_t   store_data,
	// ALU
	output word_t   alu_a,
	output word_t   alu_b,
	output opcode_t alu_op,
	input  word_t   alu_result,
	input  logic    alu_zero,
	// Output port
	output logic    out_valid,
	output word_t   out_data
);

	exec_state_t state;
	opcode_t     op_reg;         // Issued opcode
	word_t       operand_reg;    // Immediate or memory address
	word_t       acc;
	logic        zero;

	logic        take;           // Transfer this cycle

	assign take = issue && exec_idle;

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////
	assign exec_idle  = (state == E_IDLE);
	assign zero_flag  = zero;
	assign exec_addr  = operand_reg;         // LDM and STA address
	assign store_we   = (state == E_STORE);
	assign store_data = acc;
	assign alu_a      = acc;
	assign alu_b      = operand_reg;
	assign alu_op     = op_reg;
	assign out_valid  = (state == E_OUT);    // One cycle in E_OUT
	assign out_data   = acc;

	// Latch the instruction at the transfer edge
	always_ff @(posedge clk) begin
		if (take) begin
			op_reg      <= issue_op;
			operand_reg <= issue_operand;
		end
	end

	////////////////////////////////////////////////////////////
	// Execute FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= E_IDLE;
			acc   <= '0;
			zero  <= 1'b0;
		end else begin
			case (state)
				E_IDLE: begin
					if (take) begin
						case (issue_op)
							OP_LDI, OP_ADDI, OP_SUBI,
							OP_ANDI, OP_XORI: state <= E_ALU;
							OP_LDM:           state <= E_LOAD;
							OP_STA:           state <= E_STORE;
							OP_OUT:           state <= E_OUT;
							default:          state <= E_IDLE;
						endcase
					end
				end
				E_ALU: begin
					acc   <= alu_result;    // Write back result and flag
					zero  <= alu_zero;
					state <= E_IDLE;
				end
				E_LOAD: begin
					acc   <= exec_data;
					zero  <= (exec_data == '0);
					state <= E_IDLE;
				end
				E_STORE: state <= E_IDLE;   // Write happens on this edge
				E_OUT:   state <= E_IDLE;
				default: state <= E_IDLE;
			endcase
		end
	end

endmodule

// File: logic/acc_alu.sv
`timescale 1ns/1ps

module acc_alu import acc_pkg::*; (
	input  word_t   alu_a,         // Accumulator
	input  word_t   alu_b,         // Immediate operand
	input  opcode_t alu_op,
	output word_t   alu_result,
	output logic    alu_zero
);

	////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////
	always_comb begin
		case (alu_op)
			OP_LDI: begin
				alu_result = alu_b;            // Pass B through
			end
			OP_ADDI: begin
				alu_result = alu_a + alu_b;    // Wraps modulo 256
			end
			OP_SUBI: begin
				alu_result = alu_a - alu_b;    // Wraps modulo 256
			end
			OP_ANDI: begin
				alu_result = alu_a & alu_b;
			end
			OP_XORI: begin
				alu_result = alu_a ^ alu_b;
			end
			default: begin
				alu_result = '0;               // No ALU operation
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Flags
	////////////////////////////////////////////////////////////
	// Zero detect on the final result
	assign alu_zero = (alu_result == '0);

endmodule

// File: logic/acc_cpu.sv
`timescale 1ns/1ps

module acc_cpu import acc_pkg::*; #(
	parameter int    STACK_DEPTH = 4,
	parameter addr_t RESET_PC    = '0
) (
	input  logic  clk,
	input  logic  reset,
	// Program load port
	input  logic  load_we,
	input  addr_t load_addr,
	input  word_t load_data,
	// Output port
	output logic  out_valid,
	output word_t out_data,
	output logic  halted
);

	////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////
	addr_t   fetch_addr;
	word_t   fetch_data;
	addr_t   exec_addr;
	word_t   exec_data;
	logic    store_we;
	word_t   store_data;

	logic    issue;          // Fetch has work
	opcode_t issue_op;
	word_t   issue_operand;
	logic    exec_idle;      // Execute can take it
	logic    zero_flag;

	logic    push;
	logic    pop;
	addr_t   push_addr;
	addr_t   top_addr;

	word_t   alu_a;
	word_t   alu_b;
	opcode_t alu_op;
	word_t   alu_result;
	logic    alu_zero;

	acc_mem u_mem (
		.clk        (clk),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.store_we   (store_we),
		.exec_addr  (exec_addr),
		.store_data (store_data),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data),
		.exec_data  (exec_data)
	);

	return_stack #(
		.STACK_DEPTH (STACK_DEPTH)
	) u_stack (
		.clk       (clk),
		.reset     (reset),
		.push      (push),
		.pop       (pop),
		.push_addr (push_addr),
		.top_addr  (top_addr)
	);

	fetch_ctrl #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk           (clk),
		.reset         (reset),
		.fetch_addr    (fetch_addr),
		.fetch_data    (fetch_data),
		.issue         (issue),
		.issue_op      (issue_op),
		.issue_operand (issue_operand),
		.exec_idle     (exec_idle),
		.zero_flag     (zero_flag),
		.push          (push),
		.pop           (pop),
		.push_addr     (push_addr),
		.top_addr      (top_addr),
		.halted        (halted)
	);

	exec_ctrl u_exec (
		.clk           (clk),
		.reset         (reset),
		.issue         (issue),
		.issue_op      (issue_op),
		.issue_operand (issue_operand),
		.exec_idle     (exec_idle),
		.zero_flag     (zero_flag),
		.exec_addr     (exec_addr),
		.exec_data     (exec_data),
		.store_we      (store_we),
		.store_data    (store_data),
		.alu_a         (alu_a),
		.alu_b         (alu_b),
		.alu_op        (alu_op),
		.alu_result    (alu_result),
		.alu_zero      (alu_zero),
		.out_valid     (out_valid),
		.out_data      (out_data)
	);

	acc_alu u_alu (
		.alu_a      (alu_a),
		.alu_b      (alu_b),
		.alu_op     (alu_op),
		.alu_result (alu_result),
		.alu_zero   (alu_zero)
	);

endmodule

// File: test/acc_cpu_asserts.sv
`timescale 1ns/1ps

module acc_cpu_asserts (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic exec_idle,
	input logic out_valid,
	input logic halted,
	input logic push,
	input logic pop
);

	// Fetch drops its work only after execute took it
	issue_held: assert property (@(posedge clk) disable iff (reset)
		$fell(issue) |-> $past(exec_idle))
		else $error("issue dropped without a transfer");

	out_pulse: assert property (@(posedge clk) disable iff (reset)
		out_valid |=> !out_valid)
		else $error("out_valid high for two cycles");

	// Only reset clears halted
	halt_sticky: assert property (@(posedge clk)
		$fell(halted) |-> $past(reset))
		else $error("halted fell without reset");

	stack_one_op: assert property (@(posedge clk) disable iff (reset)
		!(push && pop))
		else $error("push and pop high together");

endmodule

bind acc_cpu acc_cpu_asserts u_asserts (
	.clk       (clk),
	.reset     (reset),
	.issue     (issue),
	.exec_idle (exec_idle),
	.out_valid (out_valid),
	.halted    (halted),
	.push      (push),
	.pop       (pop)
);

// File: test/acc_cpu_tb.sv
`timescale 1ns/1ps

module acc_cpu_tb import acc_pkg::*; ();

	localparam int          STACK_DEPTH     = 4;
	localparam addr_t       RESET_PC        = 8'h00;
	localparam int          NUM_PROGS       = 6;
	localparam int          CLK_HALF        = 50;
	localparam int          WATCHDOG_CYCLES = NUM_PROGS * (256 * 12 + 256 + 8);
	localparam logic [31:0] SEED            = 32'hbab6_bcae;
	localparam addr_t       FLAG_ADDR       = 8'hFF;    // Set once the deep call is made
	localparam addr_t       DONE_ADDR       = 8'hB0;    // Final OUT and HALT
	localparam addr_t       SUB_BASE        = 8'hC0;    // Subroutine chain, 8 bytes each
	localparam addr_t       BODY_END        = 8'h98;

	logic  clk;
	logic  reset;
	logic  load_we;
	addr_t load_addr;
	word_t load_data;
	logic  out_valid;
	word_t out_data;
	logic  halted;

	logic [31:0] rng_state;
	word_t       img [256];          // Program image for the next run
	word_t       model_mem [256];    // Memory as the model leaves it
	word_t       exp_out [$];
	word_t       got_out [$];
	addr_t       gen_pc;             // Generator write pointer
	logic        model_halted;
	int          error_count;
	int          pass_count;
	int          fail_count;

	acc_cpu #(
		.STACK_DEPTH (STACK_DEPTH),
		.RESET_PC    (RESET_PC)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.out_valid (out_valid),
		.out_data  (out_data),
		.halted    (halted)
	);

	initial clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	// Output bytes, sampled away from the rising edge
	always @(negedge clk) begin
		if (!reset && out_valid === 1'b1)
			got_out.push_back(out_data);
	end

	////////////////////////////////////////////////////////////
	// Random program generator
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t rand_byte();
		rng_state = xorshift(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic emit(input word_t b);
		img[gen_pc] = b;
		gen_pc = gen_pc + 8'd1;
	endtask

	task automatic emit_with_operand(input opcode_t op, input word_t operand);
		emit({op, 3'b000});
		emit(operand);
	endtask

	task automatic emit_alu_op();
		word_t   r;
		word_t   imm;
		opcode_t op;
		r = rand_byte();
		case (r % 8'd5)
			8'd0:    op = OP_LDI;
			8'd1:    op = OP_ADDI;
			8'd2:    op = OP_SUBI;
			8'd3:    op = OP_ANDI;
			default: op = OP_XORI;
		endcase
		imm = rand_byte();
		if (imm[7:6] == 2'b00)
			imm = '0;    // Zero results now and then
		emit_with_operand(op, imm);
	endtask

	task automatic build_program();
		word_t r;
		word_t kind;
		addr_t a;
		addr_t sub;
		cond_t c;
		for (int i = 0; i < 256; i++) begin
			a = i[7:0];
			img[a] = {a[3:0], a[7:4]} ^ 8'ha5;    // Fill from the full address
		end
		img[FLAG_ADDR] = 8'h00;
		gen_pc = RESET_PC;
		emit_with_operand(OP_LDM, FLAG_ADDR);     // Second pass lands here after overflow
		emit({OP_BRA, COND_BNE});
		emit(DONE_ADDR);
		while (gen_pc < BODY_END) begin
			r = rand_byte();
			kind = r % 8'd8;
			case (kind)
				8'd2, 8'd7: begin
					emit_alu_op();                         // Flag still in flight at BRA
					c = r[3] ? r[6:4] : {1'b0, r[5:4]};
					emit({OP_BRA, c});
					emit(gen_pc + 8'd4);                   // Skip LDI and OUT
					emit_with_operand(OP_LDI, rand_byte());
					emit({OP_OUT, 3'b000});
				end
				8'd3: begin
					emit({OP_JMP, 3'b000});
					emit(gen_pc + 8'd3);
					emit(rand_byte());                     // Junk, never run
					emit(rand_byte());
				end
				8'd4: emit_with_operand(OP_BSR, SUB_BASE + 8'h08 + {3'b000, r[5:4], 3'b000});
				8'd5: begin
					if (r[3] && gen_pc > 8'd8)
						a = 8'd4 + (rand_byte() % (gen_pc - 8'd4));    // Over code already run
					else
						a = 8'hF0 + {5'b00000, r[6:4]};
					emit_with_operand(OP_LDI, rand_byte());
					emit_with_operand(OP_STA, a);
					emit_with_operand(OP_LDI, rand_byte());
					emit_with_operand(OP_LDM, a);
					emit({OP_OUT, 3'b000});
				end
				8'd6: emit(r[4] ? {OP_NOP, 3'b000} : {5'b01001, r[6:4]});
				default: begin
					emit_alu_op();
					emit({OP_OUT, 3'b000});
				end
			endcase
		end
		// Deep call, one level past the stack
		emit_with_operand(OP_LDI, 8'd1);
		emit_with_operand(OP_STA, FLAG_ADDR);
		emit_with_operand(OP_BSR, SUB_BASE);
		emit({OP_HALT, 3'b000});
		gen_pc = DONE_ADDR;
		emit({OP_OUT, 3'b000});
		emit({OP_HALT, 3'b000});
		for (int k = 0; k < 5; k++) begin
			sub = SUB_BASE + {2'b00, k[2:0], 3'b000};
			gen_pc = sub;
			emit_with_operand(OP_ADDI, rand_byte());
			emit({OP_OUT, 3'b000});
			if (k < 4)
				emit_with_operand(OP_BSR, sub + 8'h08);    // Chain to the next level
			emit({OP_RTS, 3'b000});
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic logic has_operand_byte(input opcode_t op);
		case (op)
			OP_LDI, OP_ADDI, OP_SUBI, OP_ANDI, OP_XORI: return 1'b1;
			OP_LDM, OP_STA, OP_BRA, OP_JMP, OP_BSR:     return 1'b1;
			default:                                    return 1'b0;
		endcase
	endfunction

	function automatic logic branch_taken(input cond_t c, input logic z);
		case (c)
			COND_BEQ: return z;
			COND_BNE: return !z;
			COND_ALW: return 1'b1;
			default:  return 1'b0;    // Remaining codes never branch
		endcase
	endfunction

	task automatic run_model();
		addr_t   pc;
		word_t   acc;
		logic    zero;
		word_t   instr;
		word_t   imm;
		opcode_t op;
		addr_t   stack [$];
		int      steps;
		for (int i = 0; i < 256; i++)
			model_mem[i[7:0]] = img[i[7:0]];
		exp_out.delete();
		pc = RESET_PC;
		acc = '0;
		zero = 1'b0;
		steps = 0;
		model_halted = 1'b0;
		while (!model_halted && steps < 4096) begin
			instr = model_mem[pc];
			pc = pc + 8'd1;
			op = instr[7:3];
			imm = '0;
			if (has_operand_byte(op)) begin
				imm = model_mem[pc];
				pc = pc + 8'd1;
			end
			case (op)
				OP_LDI:  acc = imm;
				OP_ADDI: acc = acc + imm;
				OP_SUBI: acc = acc - imm;
				OP_ANDI: acc = acc & imm;
				OP_XORI: acc = acc ^ imm;
				OP_LDM:  acc = model_mem[imm];
				OP_STA:  model_mem[imm] = acc;
				OP_OUT:  exp_out.push_back(acc);
				OP_JMP:  pc = imm;
				OP_BRA: begin
					if (branch_taken(instr[2:0], zero))
						pc = imm;
				end
				OP_BSR: begin
					stack.push_back(pc);
					if (stack.size() > STACK_DEPTH)
						void'(stack.pop_front());    // Oldest return address lost
					pc = imm;
				end
				OP_RTS: begin
					if (stack.size() == 0)
						pc = 8'h00;
					else
						pc = stack.pop_back();
				end
				OP_HALT: model_halted = 1'b1;
				default: ;
			endcase
			if (op inside {OP_LDI, OP_ADDI, OP_SUBI, OP_ANDI, OP_XORI, OP_LDM})
				zero = (acc == 8'h00);
			steps++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Load, run and check one program
	////////////////////////////////////////////////////////////
	task automatic load_program();
		@(posedge clk);
		#1;
		reset = 1'b1;
		load_we = 1'b0;
		repeat (4) @(posedge clk);
		got_out.delete();
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			#1;
			load_we = 1'b1;
			load_addr = i[7:0];
			load_data = img[i[7:0]];
		end
		@(posedge clk);
		#1;
		load_we = 1'b0;
		reset = 1'b0;
	endtask

	task automatic run_program(input int n);
		string name;
		int    errs;
		int    count;
		addr_t a;
		name = $sformatf("prog_%0d", n);
		errs = 0;
		build_program();
		run_model();
		load_program();
		while (halted !== 1'b1)
			@(negedge clk);
		repeat (4) @(negedge clk);    // Catch any late out_valid
		if (!model_halted) begin
			$display("%s: reference model never reached HALT", name);
			errs++;
		end
		if (got_out.size() != exp_out.size()) begin
			$display("MISMATCH %s: out_valid pulses expected %0d actual %0d",
				name, exp_out.size(), got_out.size());
			errs++;
		end
		count = (got_out.size() < exp_out.size()) ? got_out.size() : exp_out.size();
		for (int i = 0; i < count; i++) begin
			if (got_out[i] !== exp_out[i]) begin
				$display("MISMATCH %s: out byte %0d expected %02h actual %02h",
					name, i, exp_out[i], got_out[i]);
				errs++;
			end
		end
		for (int i = 0; i < 256; i++) begin
			a = i[7:0];
			if (UUT.u_mem.mem[a] !== model_mem[a]) begin
				$display("MISMATCH %s: mem[%02h] expected %02h actual %02h",
					name, a, model_mem[a], UUT.u_mem.mem[a]);
				errs++;
			end
		end
		if (halted !== 1'b1) begin
			$display("%s: halted dropped while the processor was stopped", name);
			errs++;
		end
		error_count += errs;
		if (errs == 0)
			pass_count++;
		else
			fail_count++;
		$display("%s: %s, %0d bytes out, %0d errors", name, (errs == 0) ? "ok" : "FAILED",
			got_out.size(), errs);
	endtask

	initial begin
		reset = 1'b1;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		rng_state = SEED;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		for (int n = 0; n < NUM_PROGS; n++)
			run_program(n);
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
			NUM_PROGS, pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog over all programs and their loads
	initial begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF);
		$display("Timeout: the processor did not halt within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: tb.f
logic/acc_pkg.sv
logic/acc_mem.sv
logic/return_stack.sv
logic/fetch_ctrl.sv
logic/exec_ctrl.sv
logic/acc_alu.sv
logic/acc_cpu.sv
test/acc_cpu_asserts.sv
test/acc_cpu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f tb.f \
	--top-module acc_cpu_tb \
	-o acc_cpu_sim

out=$(./obj_dir/acc_cpu_sim) || true
echo "$out"

echo "$out" | grep -qx "Testbench passed"
